// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_mem_subsystem
FILE_LIST := files.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILE_LIST) $(shell cat $(FILE_LIST)) mem_trace.txt
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

# The simulation binary exits with a failing status on $fatal.
run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

// ==== files.f ====
mem_pkg.sv
tag_issuer.sv
resp_scheduler.sv
returner.sv
mem_subsystem_top.sv
tb_mem_subsystem.sv

// ==== mem_pkg.sv ====
package mem_pkg;

	// Data and address widths of the word-addressed memory.
	localparam int data_width = 32;
	localparam int addr_width = 8;

	// Sequence tags index the reorder arrays directly.
	localparam int tag_width = 6;
	localparam int tag_depth = 64;

	localparam logic kind_read = 1'b0;
	localparam logic kind_write = 1'b1;

	// Response latency per bank, selected by the low two address bits.
	localparam int bank_lat_0 = 2;
	localparam int bank_lat_1 = 5;
	localparam int bank_lat_2 = 3;
	localparam int bank_lat_3 = 7;

	// Length of the response delay line.
	localparam int sched_slots = 16;

endpackage

// ==== mem_subsystem_top.sv ====
`timescale 1ns/1ps

module mem_subsystem_top (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                req,
	input  logic                                kind,
	input  logic [mem_pkg::addr_width-1:0]      addr,
	input  logic [mem_pkg::data_width-1:0]      wdata,
	output logic                                busy,
	output logic                                read_done,
	output logic                                write_done,
	output logic [mem_pkg::data_width-1:0]      data_out
);

	logic                           iss_valid;
	logic                           iss_kind;
	logic [mem_pkg::addr_width-1:0] iss_addr;
	logic [mem_pkg::data_width-1:0] iss_wdata;
	logic [mem_pkg::tag_width-1:0]  iss_tag;

	logic                           rsp_valid;
	logic                           rsp_kind;
	logic [mem_pkg::data_width-1:0] rsp_data;
	logic [mem_pkg::tag_width-1:0]  rsp_tag;

	tag_issuer tag_issuer0 (
		.clk        (clk),
		.rst_n      (rst_n),
		.req        (req),
		.kind       (kind),
		.addr       (addr),
		.wdata      (wdata),
		.read_done  (read_done),
		.write_done (write_done),
		.busy       (busy),
		.iss_valid  (iss_valid),
		.iss_kind   (iss_kind),
		.iss_addr   (iss_addr),
		.iss_wdata  (iss_wdata),
		.iss_tag    (iss_tag)
	);

	resp_scheduler resp_scheduler0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.iss_valid (iss_valid),
		.iss_kind  (iss_kind),
		.iss_addr  (iss_addr),
		.iss_wdata (iss_wdata),
		.iss_tag   (iss_tag),
		.rsp_valid (rsp_valid),
		.rsp_kind  (rsp_kind),
		.rsp_data  (rsp_data),
		.rsp_tag   (rsp_tag)
	);

	returner returner0 (
		.clk        (clk),
		.rst_n      (rst_n),
		.valid      (rsp_valid),
		.the_type   (rsp_kind),
		.data_in    (rsp_data),
		.index      (rsp_tag),
		.write_done (write_done),
		.read_done  (read_done),
		.data_out   (data_out)
	);

endmodule

// ==== mem_trace.txt ====
// Columns: kind (0 read, 1 write), word address, write data, expected read data.
// All fields are hex; write data is zero for reads and expected data is zero for writes.
0 00 00000000 00000000
1 01 11111111 00000000
1 02 22222222 00000000
1 03 33333333 00000000
1 04 44444444 00000000
0 03 00000000 33333333
0 01 00000000 11111111
0 02 00000000 22222222
0 04 00000000 44444444
1 07 a5a5a5a5 00000000
0 07 00000000 a5a5a5a5
1 08 0badf00d 00000000
0 08 00000000 0badf00d
1 07 5a5a5a5a 00000000
0 07 00000000 5a5a5a5a
0 10 00000000 00000000
1 13 deadbeef 00000000
1 10 cafef00d 00000000
0 13 00000000 deadbeef
0 10 00000000 cafef00d
0 0f 00000000 00000000
0 05 00000000 00000000
1 05 12345678 00000000
0 05 00000000 12345678
1 02 87654321 00000000
0 02 00000000 87654321
0 01 00000000 11111111
1 ff ffff0000 00000000
0 ff 00000000 ffff0000
0 00 00000000 00000000
1 00 00c0ffee 00000000
0 00 00000000 00c0ffee

// ==== resp_scheduler.sv ====
`timescale 1ns/1ps

module resp_scheduler (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                iss_valid,
	input  logic                                iss_kind,
	input  logic [mem_pkg::addr_width-1:0]      iss_addr,
	input  logic [mem_pkg::data_width-1:0]      iss_wdata,
	input  logic [mem_pkg::tag_width-1:0]       iss_tag,
	output logic                                rsp_valid,
	output logic                                rsp_kind,
	output logic [mem_pkg::data_width-1:0]      rsp_data,
	output logic [mem_pkg::tag_width-1:0]       rsp_tag
);

	logic [mem_pkg::data_width-1:0] mem [2**mem_pkg::addr_width];

	// Delay line. Slot 0 is the response leaving this cycle.
	logic [mem_pkg::sched_slots-1:0] slot_valid;
	logic                            slot_kind [mem_pkg::sched_slots];
	logic [mem_pkg::data_width-1:0]  slot_data [mem_pkg::sched_slots];
	logic [mem_pkg::tag_width-1:0]   slot_tag  [mem_pkg::sched_slots];

	// Occupancy of each slot after this cycle's shift.
	logic [mem_pkg::sched_slots-1:0] shifted_valid;

	int                                       lat;
	logic                                     found;
	logic [$clog2(mem_pkg::sched_slots)-1:0]  ins_slot;
	logic [mem_pkg::data_width-1:0]           ins_data;

	always_comb begin
		case (iss_addr[1:0])
			2'd0: lat = mem_pkg::bank_lat_0;
			2'd1: lat = mem_pkg::bank_lat_1;
			2'd2: lat = mem_pkg::bank_lat_2;
			default: lat = mem_pkg::bank_lat_3;
		endcase
	end

	assign shifted_valid = {1'b0, slot_valid[mem_pkg::sched_slots-1:1]};

	// The top slot is always empty after the shift, so the search never fails.
	always_comb begin
		found = 1'b0;
		ins_slot = '0;
		for (int j = 0; j < mem_pkg::sched_slots; j++) begin
			if (!found && j >= lat && !shifted_valid[j]) begin
				found = 1'b1;
				ins_slot = j[$clog2(mem_pkg::sched_slots)-1:0];
			end
		end
	end

	// A read samples the array at acceptance, after all earlier writes landed.
	assign ins_data = (iss_kind == mem_pkg::kind_read) ? mem[iss_addr] : '0;

	always_ff @(posedge clk) begin
		if (rst_n) begin
			slot_valid <= '0;
			for (int i = 0; i < 2**mem_pkg::addr_width; i++) begin
				mem[i] <= '0;
			end
		end else begin
			slot_valid <= shifted_valid;
			if (iss_valid) begin
				slot_valid[ins_slot] <= 1'b1;
				if (iss_kind == mem_pkg::kind_write) begin
					mem[iss_addr] <= iss_wdata;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < mem_pkg::sched_slots - 1; i++) begin
			slot_kind[i] <= slot_kind[i+1];
			slot_data[i] <= slot_data[i+1];
			slot_tag[i] <= slot_tag[i+1];
		end
		if (iss_valid) begin
			slot_kind[ins_slot] <= iss_kind;
			slot_data[ins_slot] <= ins_data;
			slot_tag[ins_slot] <= iss_tag;
		end
	end

	assign rsp_valid = slot_valid[0];
	assign rsp_kind = slot_kind[0];
	assign rsp_data = slot_data[0];
	assign rsp_tag = slot_tag[0];

endmodule

// ==== returner.sv ====
`timescale 1ns/1ps

module returner (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                valid,
	input  logic                                the_type,
	input  logic [mem_pkg::data_width-1:0]      data_in,
	input  logic [mem_pkg::tag_width-1:0]       index,
	output logic                                write_done,
	output logic                                read_done,
	output logic [mem_pkg::data_width-1:0]      data_out
);

	// Tag expected next for each type.
	logic [mem_pkg::tag_width-1:0] read_counter;
	logic [mem_pkg::tag_width-1:0] write_counter;

	// Parked reads keep their data; parked writes need only a flag.
	logic [mem_pkg::tag_depth-1:0] read_valid;
	logic [mem_pkg::data_width-1:0] read_data [mem_pkg::tag_depth];
	logic [mem_pkg::tag_depth-1:0] write_valid;

	logic in_read;
	logic in_write;

	logic read_hit_new;
	logic read_hit_old;
	logic read_release;
	logic write_hit_new;
	logic write_hit_old;
	logic write_release;

	logic [mem_pkg::data_width-1:0] read_release_data;

	assign in_read = valid && (the_type == mem_pkg::kind_read);
	assign in_write = valid && (the_type == mem_pkg::kind_write);

	// An incoming response that is already due bypasses the arrays.
	assign read_hit_new = in_read && (index == read_counter);
	assign read_hit_old = read_valid[read_counter];
	assign read_release = read_hit_new || read_hit_old;

	assign write_hit_new = in_write && (index == write_counter);
	assign write_hit_old = write_valid[write_counter];
	assign write_release = write_hit_new || write_hit_old;

	assign read_release_data = read_hit_old ? read_data[read_counter] : data_in;

	always_ff @(posedge clk) begin
		if (rst_n) begin
			read_counter <= '0;
			write_counter <= '0;
			read_valid <= '0;
			write_valid <= '0;
			read_done <= 1'b0;
			write_done <= 1'b0;
			data_out <= '0;
		end else begin
			read_done <= read_release;
			write_done <= write_release;
			data_out <= read_release ? read_release_data : '0;

			if (read_release) begin
				read_counter <= read_counter + 1'b1;
				read_valid[read_counter] <= 1'b0;
			end
			if (write_release) begin
				write_counter <= write_counter + 1'b1;
				write_valid[write_counter] <= 1'b0;
			end

			// Tags are unique in flight, so a parked entry never collides with the release.
			if (in_read && !read_hit_new) begin
				read_valid[index] <= 1'b1;
			end
			if (in_write && !write_hit_new) begin
				write_valid[index] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (in_read && !read_hit_new) begin
			read_data[index] <= data_in;
		end
	end

endmodule

// ==== tag_issuer.sv ====
`timescale 1ns/1ps

module tag_issuer (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                req,
	input  logic                                kind,
	input  logic [mem_pkg::addr_width-1:0]      addr,
	input  logic [mem_pkg::data_width-1:0]      wdata,
	input  logic                                read_done,
	input  logic                                write_done,
	output logic                                busy,
	output logic                                iss_valid,
	output logic                                iss_kind,
	output logic [mem_pkg::addr_width-1:0]      iss_addr,
	output logic [mem_pkg::data_width-1:0]      iss_wdata,
	output logic [mem_pkg::tag_width-1:0]       iss_tag
);

	logic [mem_pkg::tag_width-1:0] rd_tag;
	logic [mem_pkg::tag_width-1:0] wr_tag;

	// One extra bit so that a full set of tag_depth requests can be counted.
	logic [mem_pkg::tag_width:0] rd_out;
	logic [mem_pkg::tag_width:0] wr_out;

	logic rd_issue;
	logic wr_issue;

	function automatic logic [mem_pkg::tag_width:0] next_count(
		input logic [mem_pkg::tag_width:0] count,
		input logic                        inc,
		input logic                        dec
	);
		logic [mem_pkg::tag_width:0] result;
		result = count;
		if (inc && !dec) begin
			result = count + 1'b1;
		end else if (dec && !inc) begin
			result = count - 1'b1;
		end
		return result;
	endfunction

	assign rd_issue = req && (kind == mem_pkg::kind_read);
	assign wr_issue = req && (kind == mem_pkg::kind_write);

	// The host sees busy as soon as either type has every tag in flight.
	assign busy = (rd_out == (mem_pkg::tag_width + 1)'(mem_pkg::tag_depth)) ||
		(wr_out == (mem_pkg::tag_width + 1)'(mem_pkg::tag_depth));

	always_ff @(posedge clk) begin
		if (rst_n) begin
			iss_valid <= 1'b0;
			rd_tag <= '0;
			wr_tag <= '0;
			rd_out <= '0;
			wr_out <= '0;
		end else begin
			iss_valid <= req;
			if (rd_issue) begin
				rd_tag <= rd_tag + 1'b1;
			end
			if (wr_issue) begin
				wr_tag <= wr_tag + 1'b1;
			end
			rd_out <= next_count(rd_out, rd_issue, read_done);
			wr_out <= next_count(wr_out, wr_issue, write_done);
		end
	end

	always_ff @(posedge clk) begin
		if (req) begin
			iss_kind <= kind;
			iss_addr <= addr;
			iss_wdata <= wdata;
			iss_tag <= (kind == mem_pkg::kind_read) ? rd_tag : wr_tag;
		end
	end

endmodule

// ==== tb_mem_subsystem.sv ====
`timescale 1ns/1ps

module tb_mem_subsystem;

	localparam int trace_len = 32;
	localparam int trace_words = trace_len * 4;
	localparam int timeout_cycles = trace_len * 8 + 200;

	logic                               clk;
	logic                               rst_n;
	logic                               req;
	logic                               kind;
	logic [mem_pkg::addr_width-1:0]     addr;
	logic [mem_pkg::data_width-1:0]     wdata;
	logic                               busy;
	logic                               read_done;
	logic                               write_done;
	logic [mem_pkg::data_width-1:0]     data_out;

	// Each trace line holds kind, address, write data and expected read data as four words.
	logic [31:0] trace_mem [trace_words];

	logic [mem_pkg::data_width-1:0] exp_reads [$];
	logic [mem_pkg::data_width-1:0] front_data;
	int                             writes_issued;
	int                             writes_done;
	int                             cycle_count;
	integer                         seed = 32'h2b98b51a;

	mem_subsystem_top dut0 (
		.clk        (clk),
		.rst_n      (rst_n),
		.req        (req),
		.kind       (kind),
		.addr       (addr),
		.wdata      (wdata),
		.busy       (busy),
		.read_done  (read_done),
		.write_done (write_done),
		.data_out   (data_out)
	);

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1, "Simulation stopped after a failure.");
	endtask

	task automatic report_mismatch(input string what);
		stop_with_failure($sformatf("ERR t=%0t ns: %s", $time, what));
	endtask

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// The run must drain within a bound that scales with the trace length.
	initial begin
		cycle_count = 0;
		forever begin
			@(posedge clk);
			cycle_count = cycle_count + 1;
			if (cycle_count >= timeout_cycles) begin
				stop_with_failure("Timeout: the run did not drain before the cycle limit.");
			end
		end
	end

	// Outputs are registered on the rising edge, so the falling edge sees them settled.
	always @(negedge clk) begin
		if (!rst_n) begin
			if (read_done) begin
				assert (exp_reads.size() > 0)
				else report_mismatch("read_done pulsed with no read outstanding");
				front_data = exp_reads.pop_front();
				assert (data_out == front_data)
				else report_mismatch($sformatf("read data %08h, expected %08h",
					data_out, front_data));
			end else begin
				assert (data_out == '0)
				else report_mismatch($sformatf("data_out %08h while read_done is low",
					data_out));
			end
			if (write_done) begin
				writes_done = writes_done + 1;
				assert (writes_done <= writes_issued)
				else report_mismatch($sformatf("%0d write completions for %0d writes issued",
					writes_done, writes_issued));
			end
		end
	end

	initial begin
		rst_n = 1'b1;
		req = 1'b0;
		kind = mem_pkg::kind_read;
		addr = '0;
		wdata = '0;
		writes_issued = 0;
		writes_done = 0;

		// A kind word left at this fill value shows that the trace did not load.
		for (int i = 0; i < trace_words; i++) begin
			trace_mem[i] = 32'hdead0000 | i;
		end
		$readmemh("mem_trace.txt", trace_mem);
		for (int i = 0; i < trace_len; i++) begin
			assert (trace_mem[4*i] <= 32'd1)
			else stop_with_failure("The trace file is missing or has a bad kind column.");
		end

		repeat (5) @(posedge clk);
		#2;
		rst_n = 1'b0;

		assert (!read_done && !write_done && !busy)
		else report_mismatch("done or busy is high right after reset");
		assert (data_out == '0)
		else report_mismatch($sformatf("data_out %08h right after reset", data_out));

		for (int i = 0; i < trace_len; i++) begin
			while ((($random(seed) & 3) == 0) || busy) begin
				req = 1'b0;
				@(posedge clk);
				#2;
			end
			req = 1'b1;
			kind = trace_mem[4*i][0];
			addr = trace_mem[4*i+1][mem_pkg::addr_width-1:0];
			wdata = trace_mem[4*i+2];
			if (kind == mem_pkg::kind_read) begin
				exp_reads.push_back(trace_mem[4*i+3]);
			end else begin
				writes_issued = writes_issued + 1;
			end
			@(posedge clk);
			#2;
		end
		req = 1'b0;

		while (exp_reads.size() != 0 || writes_done != writes_issued) begin
			@(posedge clk);
		end

		// A quiet stretch longer than the delay line exposes any stray completion.
		repeat (mem_pkg::sched_slots + 4) @(posedge clk);
		#2;

		assert (!busy)
		else report_mismatch("busy is still high after all requests completed");

		$display("RESULT: PASS");
		$finish;
	end

endmodule
